// File: rtl/usb_buf_pkg.sv
// buffer geometry and payload types; imported by the buffer, the host port and the testbench
`default_nettype none

package usb_buf_pkg;

  // ************************************************************
  // geometry
  // ************************************************************
  localparam int buf_depth = 64;  // byte slots in the shared FIFO
  localparam int ptr_width = 6;   // log2(buf_depth), pointers wrap for free
  localparam int occ_width = 7;   // one extra bit so a full buffer (64) fits

  // ************************************************************
  // payload types
  // ************************************************************

  // transfer size code, 0..3 means 1..4 bytes
  typedef logic [1:0] size_t;

  typedef logic [occ_width-1:0] occ_t;  // occupancy count 0..64

  typedef logic [7:0] byte_t;  // usb side granule

  // host side word, little-endian byte lanes
  typedef logic [31:0] word_t;

endpackage

`default_nettype wire

// File: rtl/host_bus_pkg.sv
// register map and bus widths of the host port; imported by the host port and the testbench
`default_nettype none

package host_bus_pkg;

  // ************************************************************
  // bus widths
  // ************************************************************
  localparam int addr_width = 4;  // byte address, word aligned registers

  typedef logic [addr_width-1:0] addr_t;

  // ************************************************************
  // register map
  // ************************************************************
  localparam addr_t reg_data   = 4'h0;  // write pushes a tx word, read pops an rx word
  localparam addr_t reg_status = 4'h4;  // read only, occupancy in the low bits
  localparam addr_t reg_ctrl   = 4'h8;  // clear strobe and reserved level

  // control register bits
  localparam int ctrl_clear_bit    = 0;  // write 1 for a one-cycle clear
  localparam int ctrl_reserved_bit = 1;  // level, follows the written value

endpackage

`default_nettype wire

// File: rtl/data_buffer.sv
// 64-byte circular FIFO between the usb byte side and the host word side; used under the top
`timescale 1ns/100ps
`default_nettype none

module data_buffer (
  input  wire logic                tb_clk,
  input  wire logic                reset,
  input  wire logic                clear,                 // one-cycle flush from host port
  input  wire logic                store_rx_packet_data,  // usb rx byte strobe
  input  wire usb_buf_pkg::byte_t  rx_packet_data,
  input  wire logic                get_rx_data,           // host word pop
  input  wire usb_buf_pkg::size_t  data_size,
  input  wire usb_buf_pkg::word_t  tx_data,
  input  wire logic                store_tx_data,         // host word push
  input  wire logic                get_tx_packet_data,    // usb tx byte pop
  input  wire logic                buffer_reserved,       // ownership level, status only
  output usb_buf_pkg::occ_t        buffer_occupancy,
  output usb_buf_pkg::word_t       rx_data,               // combinational word view
  output usb_buf_pkg::byte_t       tx_packet_data         // registered tx byte
);

  import usb_buf_pkg::*;

  typedef logic [2:0]           cnt_t;  // 0..4 bytes moved in one cycle
  typedef logic [ptr_width-1:0] ptr_t;

  // ************************************************************
  // storage and state
  // ************************************************************
  byte_t mem [buf_depth];  // byte slots, payload only
  ptr_t  rd_ptr;           // oldest byte
  ptr_t  wr_ptr;           // next free slot
  occ_t  occ;

  occ_t  free_slots;
  cnt_t  wr_want;
  cnt_t  wr_cnt;           // bytes actually stored this cycle
  cnt_t  rd_want;
  cnt_t  rd_cnt;           // bytes actually popped this cycle
  cnt_t  view_cnt;         // bytes shown on rx_data
  logic  tx_pop;           // byte pop toward usb tx
  byte_t wr_lane [4];
  ptr_t  wr_addr [4];
  ptr_t  rd_addr [4];

  // limit a request to what the buffer can give or take
  function automatic cnt_t cap_count(cnt_t want, occ_t limit);
    if (occ_t'(want) > limit) begin
      return limit[2:0];  // limit < want <= 4 here, so it fits
    end
    return want;
  endfunction

  // ************************************************************
  // per-cycle byte counts
  // ************************************************************
  always_comb begin
    free_slots = occ_t'(buf_depth) - occ;

    // write side, host word wins over a usb byte
    wr_want = '0;
    for (int i = 0; i < 4; i++) begin
      wr_lane[i] = tx_data[8*i +: 8];  // low byte first
    end
    if (store_tx_data) begin
      wr_want = cnt_t'(data_size) + cnt_t'(1);
    end else if (store_rx_packet_data) begin
      wr_want    = cnt_t'(1);
      wr_lane[0] = rx_packet_data;
    end
    wr_cnt = cap_count(wr_want, free_slots);  // overflow drops the rest

    // read side, host word pop wins over a usb byte pop
    tx_pop  = get_tx_packet_data && !get_rx_data;
    rd_want = '0;
    if (get_rx_data) begin
      rd_want = cnt_t'(data_size) + cnt_t'(1);
    end else if (tx_pop) begin
      rd_want = cnt_t'(1);
    end
    rd_cnt = cap_count(rd_want, occ);  // underflow pops only what is there

    view_cnt = cap_count(cnt_t'(data_size) + cnt_t'(1), occ);
  end

  // lane addresses, wrap modulo 64 through the pointer width
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      wr_addr[i] = wr_ptr + ptr_t'(i);
      rd_addr[i] = rd_ptr + ptr_t'(i);
    end
  end

  // ************************************************************
  // host word view
  // ************************************************************
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      if (cnt_t'(i) < view_cnt) begin
        rx_data[8*i +: 8] = mem[rd_addr[i]];
      end else begin
        rx_data[8*i +: 8] = '0;  // missing upper lanes
      end
    end
  end

  // byte array write, lanes beyond wr_cnt are dropped
  always_ff @(posedge tb_clk) begin
    if (!clear) begin
      for (int i = 0; i < 4; i++) begin
        if (cnt_t'(i) < wr_cnt) begin
          mem[wr_addr[i]] <= wr_lane[i];
        end
      end
    end
  end

  // pointers and occupancy, net change when store and pop coincide
  always_ff @(posedge tb_clk) begin
    if (reset || clear) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      occ    <= '0;
    end else begin
      wr_ptr <= wr_ptr + ptr_t'(wr_cnt);
      rd_ptr <= rd_ptr + ptr_t'(rd_cnt);
      occ    <= occ + occ_t'(wr_cnt) - occ_t'(rd_cnt);
    end
  end

  // ************************************************************
  // usb tx byte
  // ************************************************************
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      tx_packet_data <= '0;
    end else if (tx_pop) begin
      if (rd_cnt != '0) begin
        tx_packet_data <= mem[rd_ptr];
      end else begin
        tx_packet_data <= '0;  // empty pop reads zero
      end
    end
  end

  assign buffer_occupancy = occ;

endmodule

`default_nettype wire

// File: rtl/buffer_host_port.sv
// host register port: turns bus strobes into buffer controls and registers read data
`timescale 1ns/100ps
`default_nettype none

module buffer_host_port (
  input  wire logic                 tb_clk,
  input  wire logic                 reset,
  input  wire logic                 bus_sel,        // access strobe, one per cycle
  input  wire logic                 bus_write,      // 1 write, 0 read
  input  wire host_bus_pkg::addr_t  bus_addr,
  input  wire usb_buf_pkg::size_t   bus_size,       // bytes minus one
  input  wire usb_buf_pkg::word_t   bus_wdata,
  output usb_buf_pkg::word_t        bus_rdata,      // registered, held until next read
  input  wire usb_buf_pkg::word_t   rx_data,        // buffer word view
  input  wire usb_buf_pkg::occ_t    buffer_occupancy,
  output logic                      get_rx_data,
  output logic                      store_tx_data,
  output usb_buf_pkg::size_t        data_size,
  output usb_buf_pkg::word_t        tx_data,
  output logic                      clear,          // one-cycle flush
  output logic                      buffer_reserved
);

  import usb_buf_pkg::*;
  import host_bus_pkg::*;

  logic  data_sel;  // access to the data register
  logic  ctrl_wr;   // write to the control register
  logic  bus_rd;    // any read access
  word_t rd_mux;

  // ************************************************************
  // address decode
  // ************************************************************
  assign data_sel = bus_sel && (bus_addr == reg_data);
  assign ctrl_wr  = bus_sel && bus_write && (bus_addr == reg_ctrl);
  assign bus_rd   = bus_sel && !bus_write;

  // data strobes go straight to the buffer, same cycle
  assign get_rx_data   = data_sel && !bus_write;
  assign store_tx_data = data_sel && bus_write;
  assign data_size     = bus_size;   // size applies to both directions
  assign tx_data       = bus_wdata;  // low byte first

  // ************************************************************
  // read path
  // ************************************************************
  always_comb begin
    rd_mux = '0;  // unmapped reads return zero
    case (bus_addr)
      reg_data: begin
        rd_mux = rx_data;  // popped at this same edge
      end
      reg_status: begin
        rd_mux = word_t'(buffer_occupancy);
      end
      reg_ctrl: begin
        rd_mux[ctrl_reserved_bit] = buffer_reserved;  // clear bit reads back 0
      end
      default: begin
        rd_mux = '0;
      end
    endcase
  end

  always_ff @(posedge tb_clk) begin
    if (reset) begin
      bus_rdata <= '0;
    end else if (bus_rd) begin
      bus_rdata <= rd_mux;  // valid the cycle after the strobe
    end
  end

  // ************************************************************
  // control register
  // ************************************************************
  always_ff @(posedge tb_clk) begin
    if (reset) begin
      clear           <= 1'b0;
      buffer_reserved <= 1'b0;
    end else begin
      clear <= ctrl_wr && bus_wdata[ctrl_clear_bit];  // self clearing pulse
      if (ctrl_wr) begin
        buffer_reserved <= bus_wdata[ctrl_reserved_bit];
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/usb_buffer_top.sv
// endpoint buffer top level: host register port plus FIFO, usb byte side exposed
`timescale 1ns/100ps
`default_nettype none

module usb_buffer_top (
  input  wire logic                 tb_clk,
  input  wire logic                 reset,
  // host side
  input  wire logic                 bus_sel,
  input  wire logic                 bus_write,
  input  wire host_bus_pkg::addr_t  bus_addr,
  input  wire usb_buf_pkg::size_t   bus_size,
  input  wire usb_buf_pkg::word_t   bus_wdata,
  output usb_buf_pkg::word_t        bus_rdata,
  // usb side
  input  wire logic                 store_rx_packet_data,
  input  wire usb_buf_pkg::byte_t   rx_packet_data,
  input  wire logic                 get_tx_packet_data,
  output usb_buf_pkg::byte_t        tx_packet_data,
  output usb_buf_pkg::occ_t         buffer_occupancy
);

  import usb_buf_pkg::*;

  // host port to buffer
  logic  get_rx_data;
  logic  store_tx_data;
  size_t data_size;
  word_t tx_data;
  logic  clear;
  logic  buffer_reserved;
  word_t rx_data;  // buffer word view back to the port

  buffer_host_port u_host_port (
    .tb_clk           (tb_clk),
    .reset            (reset),
    .bus_sel          (bus_sel),
    .bus_write        (bus_write),
    .bus_addr         (bus_addr),
    .bus_size         (bus_size),
    .bus_wdata        (bus_wdata),
    .bus_rdata        (bus_rdata),
    .rx_data          (rx_data),
    .buffer_occupancy (buffer_occupancy),
    .get_rx_data      (get_rx_data),
    .store_tx_data    (store_tx_data),
    .data_size        (data_size),
    .tx_data          (tx_data),
    .clear            (clear),
    .buffer_reserved  (buffer_reserved)
  );

  data_buffer u_buffer (
    .tb_clk               (tb_clk),
    .reset                (reset),
    .clear                (clear),
    .store_rx_packet_data (store_rx_packet_data),
    .rx_packet_data       (rx_packet_data),
    .get_rx_data          (get_rx_data),
    .data_size            (data_size),
    .tx_data              (tx_data),
    .store_tx_data        (store_tx_data),
    .get_tx_packet_data   (get_tx_packet_data),
    .buffer_reserved      (buffer_reserved),
    .buffer_occupancy     (buffer_occupancy),
    .rx_data              (rx_data),
    .tx_packet_data       (tx_packet_data)
  );

endmodule

`default_nettype wire

// File: sim/usb_buffer_checker.sv
// concurrent occupancy checks, bound into every data_buffer instance of the testbench
`timescale 1ns/100ps
`default_nettype none

module usb_buffer_checker (
  input wire logic              tb_clk,
  input wire logic              reset,
  input wire logic              clear,
  input wire logic              store_rx_packet_data,
  input wire logic              get_rx_data,
  input wire logic              store_tx_data,
  input wire logic              get_tx_packet_data,
  input wire usb_buf_pkg::occ_t buffer_occupancy
);

  import usb_buf_pkg::*;

  int   assert_fails = 0;  // summed into the testbench result at the end
  logic any_strobe;        // something may move bytes this cycle

  assign any_strobe = store_rx_packet_data || get_rx_data || store_tx_data ||
                      get_tx_packet_data;

  // ************************************************************
  // occupancy rules
  // ************************************************************
  a_occ_max: assert property (@(posedge tb_clk) disable iff (reset)
    buffer_occupancy <= occ_t'(buf_depth))
    else begin
      assert_fails++;
      $error("occupancy %0d above buffer depth", buffer_occupancy);
    end

  // flush lands one cycle after the pulse
  a_clear_empty: assert property (@(posedge tb_clk) disable iff (reset)
    clear |=> (buffer_occupancy == '0))
    else begin
      assert_fails++;
      $error("occupancy not zero after clear");
    end

  a_occ_hold: assert property (@(posedge tb_clk) disable iff (reset)
    (!any_strobe && !clear) |=> $stable(buffer_occupancy))
    else begin
      assert_fails++;
      $error("occupancy moved without a strobe");
    end

endmodule

bind data_buffer usb_buffer_checker u_checker (
  .tb_clk               (tb_clk),
  .reset                (reset),
  .clear                (clear),
  .store_rx_packet_data (store_rx_packet_data),
  .get_rx_data          (get_rx_data),
  .store_tx_data        (store_tx_data),
  .get_tx_packet_data   (get_tx_packet_data),
  .buffer_occupancy     (buffer_occupancy)
);

`default_nettype wire

// File: sim/tb_usb_buffer.sv
// directed testbench for the usb endpoint buffer; run with the file list, top tb_usb_buffer
`timescale 1ns/100ps
`default_nettype none

module tb_usb_buffer;

  import usb_buf_pkg::*;
  import host_bus_pkg::*;

  logic  tb_clk;
  logic  reset;
  logic  bus_sel;
  logic  bus_write;
  addr_t bus_addr;
  size_t bus_size;
  word_t bus_wdata;
  word_t bus_rdata;
  logic  store_rx_packet_data;
  byte_t rx_packet_data;
  logic  get_tx_packet_data;
  byte_t tx_packet_data;
  occ_t  buffer_occupancy;

  byte_t       ref_q [$];  // reference FIFO, oldest byte first
  logic [31:0] lcg_state;
  int          check_count;
  int          error_count;
  int          timeout_count;

  usb_buffer_top u_dut (.*);

  always #10 tb_clk = ~tb_clk;  // 20 ns period

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  // ************************************************************
  // compare tasks
  // ************************************************************
  task automatic compare_word(word_t got, word_t exp, string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got %08h expected %08h", $time, what, got, exp);
    end
  endtask

  task automatic compare_byte(byte_t got, byte_t exp, string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic compare_occ(occ_t got, occ_t exp, string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ************************************************************
  // reference model and bus tasks
  // ************************************************************
  task automatic step();
    @(posedge tb_clk);
    #2;  // inputs change just after the edge
  endtask

  // low byte first, whatever does not fit is dropped
  function automatic void model_store(word_t w, int n);
    for (int i = 0; i < n; i++) begin
      if (ref_q.size() < buf_depth) begin
        ref_q.push_back(w[8*i +: 8]);
      end
    end
  endfunction

  function automatic word_t model_pop(size_t size);
    word_t w;
    w = '0;  // missing lanes read zero
    for (int i = 0; i <= int'(size); i++) begin
      if (ref_q.size() > 0) begin
        w[8*i +: 8] = ref_q.pop_front();
      end
    end
    return w;
  endfunction

  task automatic bus_access(logic wr, addr_t addr, size_t size, word_t wdata);
    bus_sel   = 1'b1;
    bus_write = wr;
    bus_addr  = addr;
    bus_size  = size;
    bus_wdata = wdata;
    step();             // sampled here, bus_rdata valid from now
    bus_sel   = 1'b0;
    bus_write = 1'b0;
  endtask

  task automatic usb_store(byte_t b);
    store_rx_packet_data = 1'b1;
    rx_packet_data       = b;
    step();
    store_rx_packet_data = 1'b0;
    model_store(word_t'(b), 1);
  endtask

  task automatic usb_pop();
    byte_t exp;
    exp = '0;  // empty pop
    if (ref_q.size() > 0) begin
      exp = ref_q.pop_front();
    end
    get_tx_packet_data = 1'b1;
    step();
    get_tx_packet_data = 1'b0;
    compare_byte(tx_packet_data, exp, "tx byte");
    compare_occ(buffer_occupancy, occ_t'(ref_q.size()), "occupancy after tx pop");
  endtask

  task automatic host_read_data(size_t size);
    word_t exp;
    exp = model_pop(size);
    bus_access(1'b0, reg_data, size, '0);
    compare_word(bus_rdata, exp, "rx word");
  endtask

  // usb byte and host word read at the same edge, free space taken before the pop
  task automatic store_and_read(byte_t b, size_t size);
    logic  full;
    word_t exp;
    full = (ref_q.size() >= buf_depth);
    exp  = model_pop(size);
    if (!full) begin
      ref_q.push_back(b);
    end
    store_rx_packet_data = 1'b1;
    rx_packet_data       = b;
    bus_access(1'b0, reg_data, size, '0);
    store_rx_packet_data = 1'b0;
    compare_word(bus_rdata, exp, "rx word with store");
    compare_occ(buffer_occupancy, occ_t'(ref_q.size()), "occupancy after net change");
  endtask

  task automatic check_status();
    bus_access(1'b0, reg_status, 2'd0, '0);
    compare_word(bus_rdata, word_t'(ref_q.size()), "status register");
    compare_occ(buffer_occupancy, occ_t'(ref_q.size()), "occupancy level");
  endtask

  task automatic clear_buffer();
    int n;
    bus_access(1'b1, reg_ctrl, 2'd0, word_t'(1) << ctrl_clear_bit);
    ref_q.delete();
    step();  // clear pulse cycle
    n = 0;
    while (buffer_occupancy !== '0 && n < 8) begin
      step();
      n++;
    end
    if (buffer_occupancy !== '0) begin
      timeout_count++;
      $display("timeout at %0t: occupancy never reached zero after clear", $time);
    end
  endtask

  // ************************************************************
  // directed tests
  // ************************************************************
  task automatic test_rx_words();
    for (int i = 0; i < 4; i++) begin
      usb_store(byte_t'(8'h11 * (i + 1)));
    end
    check_status();
    host_read_data(2'd3);
    check_status();
    host_read_data(2'd0);  // nothing left, zero word
    check_status();
  endtask

  task automatic test_tx_words();
    bus_access(1'b1, reg_data, 2'd0, lcg_next());
    model_store(bus_wdata, 1);
    bus_access(1'b1, reg_data, 2'd1, lcg_next());
    model_store(bus_wdata, 2);
    bus_access(1'b1, reg_data, 2'd3, lcg_next());
    model_store(bus_wdata, 4);
    check_status();
    while (ref_q.size() > 0) begin
      usb_pop();
    end
  endtask

  task automatic test_clear();
    for (int i = 0; i < 5; i++) begin
      usb_store(byte_t'(lcg_next() >> 24));
    end
    bus_access(1'b1, reg_ctrl, 2'd0, word_t'(1) << ctrl_reserved_bit);
    bus_access(1'b0, reg_ctrl, 2'd0, '0);
    compare_word(bus_rdata, word_t'(1) << ctrl_reserved_bit, "reserved readback");
    clear_buffer();
    check_status();
    host_read_data(2'd3);
  endtask

  task automatic test_overflow();
    for (int i = 0; i < 70; i++) begin
      usb_store(byte_t'(lcg_next() >> 16));  // last 6 are dropped
    end
    check_status();
    for (int i = 0; i < 15; i++) begin
      host_read_data(2'd3);
    end
    host_read_data(2'd1);
    check_status();         // two bytes left
    host_read_data(2'd3);   // upper lanes zero
    usb_pop();              // empty pop
  endtask

  task automatic test_random();
    int          stored;
    logic [31:0] r;
    stored = 0;
    while (stored < 200) begin
      r = lcg_next();
      case (r[9:8])
        2'd0, 2'd1: begin
          usb_store(r[7:0]);
          stored++;
        end
        2'd2: begin
          store_and_read(r[7:0], r[11:10]);
          stored++;
        end
        default: begin
          if (r[16]) begin
            host_read_data(r[11:10]);
          end else begin
            usb_pop();
          end
        end
      endcase
      if (r[15:12] == 4'h0) begin
        check_status();
      end
    end
    while (ref_q.size() > 0) begin
      host_read_data(2'd3);  // drain
    end
    check_status();
  endtask

  initial begin
    $timeformat(-9, 1, " ns", 0);
    tb_clk               = 1'b0;
    reset                = 1'b1;
    bus_sel              = 1'b0;
    bus_write            = 1'b0;
    bus_addr             = '0;
    bus_size             = '0;
    bus_wdata            = '0;
    store_rx_packet_data = 1'b0;
    rx_packet_data       = '0;
    get_tx_packet_data   = 1'b0;
    lcg_state            = 32'h46f89a9e;
    check_count          = 0;
    error_count          = 0;
    timeout_count        = 0;
    repeat (10) step();
    reset = 1'b0;
    compare_word(bus_rdata, '0, "bus read data after reset");
    check_status();  // empty after reset
    compare_byte(tx_packet_data, '0, "tx byte after reset");
    test_rx_words();
    test_tx_words();
    test_clear();
    test_overflow();
    test_random();
    $display("checks %0d errors %0d timeouts %0d assertion failures %0d", check_count,
             error_count, timeout_count, u_dut.u_buffer.u_checker.assert_fails);
    if (error_count == 0 && timeout_count == 0 &&
        u_dut.u_buffer.u_checker.assert_fails == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: usb_buffer.f
rtl/usb_buf_pkg.sv
rtl/host_bus_pkg.sv
rtl/data_buffer.sv
rtl/buffer_host_port.sv
rtl/usb_buffer_top.sv
sim/usb_buffer_checker.sv
sim/tb_usb_buffer.sv
